/* cart_pkg.sv */
package cart_pkg;

  // ----------------------------------------
  // bus and data widths
  // ----------------------------------------
  typedef logic [23:0] cart_addr_t;      // console or mcu byte address
  typedef logic [22:0] rom_word_addr_t;  // 16-bit rom word address
  typedef logic [18:0] ram_addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] rom_word_t;
  typedef logic [3:0]  cycle_cnt_t;      // memory cycle delay

  // ----------------------------------------
  // sequencer states
  // ----------------------------------------
  typedef enum logic [2:0] {
    rom_idle,
    rom_mcu_rd_addr,
    rom_mcu_rd_end,
    rom_mcu_wr_addr,
    rom_mcu_wr_end
  } rom_state_e;

  typedef enum logic [2:0] {
    ram_idle,
    ram_mcu_rd_addr,
    ram_mcu_rd_end,
    ram_mcu_wr_addr,
    ram_mcu_wr_end
  } ram_state_e;

  localparam cycle_cnt_t ROM_CYCLE_LEN = 4'd7;  // slow psram parts need the extra clock
  localparam cycle_cnt_t RAM_CYCLE_LEN = 4'd5;
  localparam logic [4:0] RAM_REGION = 5'b11100;    // mcu addr[23:19] for ram
  localparam int SNES_DEAD_TIMEOUT = 85714;      // ~1 ms of clocks

endpackage

/* snes_bus_if.sv */
interface snes_bus_if;
  import cart_pkg::*;

  cart_addr_t addr;  // filtered console address
  logic       read;  // filtered read level, low active
  logic       pulse_end;
  logic       dead;
  logic       revive;   // console came back, abort rom cycle

  modport sampler (
    output addr, read, pulse_end, dead, revive
  );

  modport fsm (
    input pulse_end, dead, revive
  );

  modport drv (
    input addr, read
  );

endinterface

/* mem_req_if.sv */
interface mem_req_if;
  import cart_pkg::*;

  // request side
  logic       rd_pend;
  logic       wr_pend;
  cart_addr_t addr;

  // sequencer side
  logic       active;       // sequencer owns the memory bus
  logic       write_phase;  // write strobe window
  logic       done;         // one clock in an end state
  byte_t      rd_data;

  modport port (
    output rd_pend, wr_pend, addr,
    input  done, rd_data
  );

  modport fsm (
    input  rd_pend, wr_pend, addr,
    output active, write_phase, done, rd_data
  );

  modport drv (
    input addr, active, write_phase
  );

endinterface

/* snes_bus_sampler.sv */
module snes_bus_sampler #(
  parameter int dead_timeout = cart_pkg::SNES_DEAD_TIMEOUT
) (
  input  logic                CLK2,
  input  logic                reset,
  input  cart_pkg::cart_addr_t snes_addr_in,
  input  logic                snes_read_in,
  input  logic                snes_write_in,
  input  logic                snes_cpu_clk_in,
  snes_bus_if.sampler         bus
);
  import cart_pkg::*;

  localparam int depth = 7;
  localparam int cnt_w = $clog2(dead_timeout + 2);

  logic [depth-1:0] pulse_r;  // idle pulse history, bit 0 newest
  logic [2:0]       read_r;
  logic [1:0]       clk_r;
  cart_addr_t       addr_r [2];
  logic [cnt_w-1:0] dead_cnt;
  logic             dead_hit;
  logic             pulse_in;
  logic             dead;

  // read and write both high with the cpu clock low
  assign pulse_in = snes_read_in & snes_write_in & ~snes_cpu_clk_in;

  always_ff @(posedge CLK2) begin
    if (reset) begin
      pulse_r <= '1;
      read_r  <= '1;
      clk_r   <= '0;
    end else begin
      pulse_r <= {pulse_r[depth-2:0], pulse_in};
      read_r  <= {read_r[1:0], snes_read_in};
      clk_r   <= {clk_r[0], snes_cpu_clk_in};
    end
  end

  always_ff @(posedge CLK2) begin
    addr_r[0] <= snes_addr_in;
    addr_r[1] <= addr_r[0];
  end

  // ----------------------------------------
  // dead console detection
  // ----------------------------------------
  assign dead_hit = dead_cnt > cnt_w'(dead_timeout);

  always_ff @(posedge CLK2) begin
    if (reset) begin
      dead_cnt <= '0;
      dead     <= 1'b1;  // assume no console until its clock runs
    end else if (clk_r[1]) begin
      dead_cnt <= '0;
      dead     <= 1'b0;
    end else begin
      if (!dead_hit) dead_cnt <= dead_cnt + 1'b1;  // stops once past timeout
      if (dead_hit) dead <= 1'b1;
    end
  end

  assign bus.addr      = addr_r[1] & addr_r[0];  // glitch filter on address
  assign bus.read      = read_r[2] & read_r[1];
  assign bus.pulse_end = pulse_r[depth-1:1] == 6'b000011;  // access over, bus idle
  assign bus.dead      = dead;
  assign bus.revive    = dead & clk_r[1];

endmodule

/* mcu_request_port.sv */
module mcu_request_port (
  input  logic                 CLK2,
  input  logic                 reset,
  input  cart_pkg::cart_addr_t mcu_addr,
  input  logic                 mcu_rrq,
  input  logic                 mcu_wrq,
  output cart_pkg::byte_t      mcu_din,
  output logic                 mcu_rdy,
  mem_req_if.port              rom_req,
  mem_req_if.port              ram_req
);
  import cart_pkg::*;

  logic rrq_r;
  logic wrq_r;
  logic ram_hit;
  logic rom_rdy;
  logic ram_rdy;

  // request strobes are taken one clock late
  always_ff @(posedge CLK2) begin
    if (reset) begin
      rrq_r <= 1'b0;
      wrq_r <= 1'b0;
    end else begin
      rrq_r <= mcu_rrq;
      wrq_r <= mcu_wrq;
    end
  end

  assign ram_hit = mcu_addr[23:19] == RAM_REGION;  // mcu holds addr until ready

  // ----------------------------------------
  // pending flags per memory
  // ----------------------------------------
  always_ff @(posedge CLK2) begin
    if (reset) begin
      rom_req.rd_pend <= 1'b0;
      rom_req.wr_pend <= 1'b0;
      rom_rdy         <= 1'b1;
    end else if ((rrq_r | wrq_r) && !ram_hit) begin
      rom_req.rd_pend <= rrq_r;
      rom_req.wr_pend <= ~rrq_r;  // read wins if both strobes come
      rom_rdy         <= 1'b0;
    end else if (rom_req.done) begin
      rom_req.rd_pend <= 1'b0;
      rom_req.wr_pend <= 1'b0;
      rom_rdy         <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (reset) begin
      ram_req.rd_pend <= 1'b0;
      ram_req.wr_pend <= 1'b0;
      ram_rdy         <= 1'b1;
    end else if ((rrq_r | wrq_r) && ram_hit) begin
      ram_req.rd_pend <= rrq_r;
      ram_req.wr_pend <= ~rrq_r;
      ram_rdy         <= 1'b0;
    end else if (ram_req.done) begin
      ram_req.rd_pend <= 1'b0;
      ram_req.wr_pend <= 1'b0;
      ram_rdy         <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if ((rrq_r | wrq_r) && !ram_hit) rom_req.addr <= mcu_addr;
    if ((rrq_r | wrq_r) && ram_hit) ram_req.addr <= mcu_addr;
  end

  // read data from whichever side just finished a read
  always_ff @(posedge CLK2) begin
    if (rom_req.done && rom_req.rd_pend) mcu_din <= rom_req.rd_data;
    else if (ram_req.done && ram_req.rd_pend) mcu_din <= ram_req.rd_data;
  end

  assign mcu_rdy = rom_rdy & ram_rdy;

endmodule

/* rom_access_fsm.sv */
module rom_access_fsm (
  input  logic                CLK2,
  input  logic                reset,
  snes_bus_if.fsm             bus,
  mem_req_if.fsm              req,
  input  cart_pkg::rom_word_t rom_data_in
);
  import cart_pkg::*;

  rom_state_e state;
  cycle_cnt_t delay;
  logic       free_slot;

  // mcu gets the bus right after a console access, or always when dead
  assign free_slot = bus.pulse_end | bus.dead;

  always_ff @(posedge CLK2) begin
    if (reset) begin
      state <= rom_idle;
      delay <= '0;
    end else if (bus.revive) begin
      state <= rom_idle;  // pending flag stays, cycle restarts later
    end else begin
      case (state)
        rom_idle: begin
          if (free_slot && req.rd_pend) begin
            state <= rom_mcu_rd_addr;
            delay <= ROM_CYCLE_LEN;
          end else if (free_slot && req.wr_pend) begin
            state <= rom_mcu_wr_addr;
            delay <= ROM_CYCLE_LEN;
          end
        end
        rom_mcu_rd_addr: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= rom_mcu_rd_end;
        end
        rom_mcu_wr_addr: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= rom_mcu_wr_end;
        end
        default: state <= rom_idle;  // both end states
      endcase
    end
  end

  // odd bytes sit in the low lane
  always_ff @(posedge CLK2) begin
    if (state == rom_mcu_rd_addr)
      req.rd_data <= req.addr[0] ? rom_data_in[7:0] : rom_data_in[15:8];
  end

  assign req.active      = state != rom_idle;
  assign req.write_phase = state == rom_mcu_wr_addr;
  assign req.done        = (state == rom_mcu_rd_end) || (state == rom_mcu_wr_end);

endmodule

/* ram_access_fsm.sv */
module ram_access_fsm (
  input  logic            CLK2,
  input  logic            reset,
  mem_req_if.fsm          req,
  input  cart_pkg::byte_t ram_data_in
);
  import cart_pkg::*;

  ram_state_e state;
  cycle_cnt_t delay;

  // ram belongs to the mcu alone, start as soon as a request is pending
  always_ff @(posedge CLK2) begin
    if (reset) begin
      state <= ram_idle;
      delay <= '0;
    end else begin
      case (state)
        ram_idle: begin
          if (req.rd_pend) begin
            state <= ram_mcu_rd_addr;
            delay <= RAM_CYCLE_LEN;
          end else if (req.wr_pend) begin
            state <= ram_mcu_wr_addr;
            delay <= RAM_CYCLE_LEN;
          end
        end
        ram_mcu_rd_addr: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= ram_mcu_rd_end;
        end
        ram_mcu_wr_addr: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= ram_mcu_wr_end;
        end
        default: state <= ram_idle;
      endcase
    end
  end

  always_ff @(posedge CLK2) begin
    if (state == ram_mcu_rd_addr) req.rd_data <= ram_data_in;  // last sample wins
  end

  assign req.active      = state != ram_idle;
  assign req.write_phase = state == ram_mcu_wr_addr;
  assign req.done        = (state == ram_mcu_rd_end) || (state == ram_mcu_wr_end);

endmodule

/* mem_bus_driver.sv */
module mem_bus_driver (
  snes_bus_if.drv                  bus,
  mem_req_if.drv                   rom_req,
  mem_req_if.drv                   ram_req,
  input  cart_pkg::byte_t          mcu_dout,
  input  cart_pkg::rom_word_t      rom_data_in,
  output cart_pkg::byte_t          snes_data_out,
  output logic                     snes_data_oe,
  output cart_pkg::rom_word_addr_t rom_addr,
  output cart_pkg::rom_word_t      rom_data_out,
  output logic                     rom_we,
  output logic                     rom_bhe,
  output logic                     rom_ble,
  output cart_pkg::ram_addr_t      ram_addr,
  output cart_pkg::byte_t          ram_data_out,
  output logic                     ram_we
);

  logic rom_a0;  // byte select of the current rom owner

  // ----------------------------------------
  // rom bus
  // ----------------------------------------
  assign rom_addr = rom_req.active ? rom_req.addr[23:1] : bus.addr[23:1];
  assign rom_a0   = rom_req.active ? rom_req.addr[0] : bus.addr[0];

  assign rom_bhe = rom_a0;   // even byte, high lane
  assign rom_ble = ~rom_a0;  // odd byte, low lane

  assign rom_we       = ~rom_req.write_phase;
  assign rom_data_out = {mcu_dout, mcu_dout};  // lane enables pick the byte

  // ----------------------------------------
  // ram bus
  // ----------------------------------------
  assign ram_addr     = ram_req.active ? ram_req.addr[18:0] : '0;  // park when idle
  assign ram_we       = ~ram_req.write_phase;
  assign ram_data_out = mcu_dout;

  // console read path
  assign snes_data_out = bus.addr[0] ? rom_data_in[7:0] : rom_data_in[15:8];
  assign snes_data_oe  = ~bus.read;

endmodule

/* cart_mem_ctrl.sv */
module cart_mem_ctrl #(
  parameter int dead_timeout = cart_pkg::SNES_DEAD_TIMEOUT
) (
  input  logic                     CLK2,
  input  logic                     reset,
  // console bus
  input  cart_pkg::cart_addr_t     snes_addr_in,
  input  logic                     snes_read_in,
  input  logic                     snes_write_in,
  input  logic                     snes_cpu_clk_in,
  output cart_pkg::byte_t          snes_data_out,
  output logic                     snes_data_oe,
  // mcu requests
  input  cart_pkg::cart_addr_t     mcu_addr,
  input  logic                     mcu_rrq,
  input  logic                     mcu_wrq,
  input  cart_pkg::byte_t          mcu_dout,
  output cart_pkg::byte_t          mcu_din,
  output logic                     mcu_rdy,
  // 16-bit rom
  input  cart_pkg::rom_word_t      rom_data_in,
  output cart_pkg::rom_word_addr_t rom_addr,
  output cart_pkg::rom_word_t      rom_data_out,
  output logic                     rom_we,
  output logic                     rom_bhe,
  output logic                     rom_ble,
  // 8-bit ram
  input  cart_pkg::byte_t          ram_data_in,
  output cart_pkg::ram_addr_t      ram_addr,
  output cart_pkg::byte_t          ram_data_out,
  output logic                     ram_we
);

  snes_bus_if snes_bus ();
  mem_req_if  rom_req ();
  mem_req_if  ram_req ();

  snes_bus_sampler #(
    .dead_timeout(dead_timeout)
  ) u_sampler (
    .CLK2            (CLK2),
    .reset           (reset),
    .snes_addr_in    (snes_addr_in),
    .snes_read_in    (snes_read_in),
    .snes_write_in   (snes_write_in),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .bus             (snes_bus)
  );

  mcu_request_port u_req_port (
    .CLK2     (CLK2),
    .reset    (reset),
    .mcu_addr (mcu_addr),
    .mcu_rrq  (mcu_rrq),
    .mcu_wrq  (mcu_wrq),
    .mcu_din  (mcu_din),
    .mcu_rdy  (mcu_rdy),
    .rom_req  (rom_req),
    .ram_req  (ram_req)
  );

  rom_access_fsm u_rom_fsm (
    .CLK2        (CLK2),
    .reset       (reset),
    .bus         (snes_bus),
    .req         (rom_req),
    .rom_data_in (rom_data_in)
  );

  ram_access_fsm u_ram_fsm (
    .CLK2        (CLK2),
    .reset       (reset),
    .req         (ram_req),
    .ram_data_in (ram_data_in)
  );

  mem_bus_driver u_driver (
    .bus           (snes_bus),
    .rom_req       (rom_req),
    .ram_req       (ram_req),
    .mcu_dout      (mcu_dout),
    .rom_data_in   (rom_data_in),
    .snes_data_out (snes_data_out),
    .snes_data_oe  (snes_data_oe),
    .rom_addr      (rom_addr),
    .rom_data_out  (rom_data_out),
    .rom_we        (rom_we),
    .rom_bhe       (rom_bhe),
    .rom_ble       (rom_ble),
    .ram_addr      (ram_addr),
    .ram_data_out  (ram_data_out),
    .ram_we        (ram_we)
  );

endmodule

/* tb_cart_mem_ctrl.sv */
module tb_cart_mem_ctrl;
  timeunit 1ns;
  timeprecision 100ps;

  import cart_pkg::*;

  typedef enum logic [1:0] {mcu_read, mcu_write, snes_read, blocked_rom} kind_e;

  typedef struct packed {
    kind_e      kind;
    cart_addr_t addr;
    byte_t      data;  // write data or expected mcu read byte
  } row_t;

  localparam int n_rows = 12;
  localparam int timeout_cycles = n_rows * 200;
  localparam int dead_cycles = 64;                // short dead timeout for simulation
  localparam int rom_wait_max = dead_cycles / 2;  // a free slot must beat the dead detector

  // rows 0..7 run with the console dead and rom addresses stay below 0x200
  localparam row_t stim [n_rows] = '{
    '{mcu_write,   24'hE0_0012, 8'hA5},
    '{mcu_read,    24'hE0_0012, 8'hA5},
    '{mcu_write,   24'hE0_0013, 8'h3C},
    '{mcu_read,    24'hE0_0013, 8'h3C},
    '{mcu_write,   24'h00_0104, 8'h5A},  // even byte, high lane
    '{mcu_write,   24'h00_0105, 8'hC3},  // odd byte, same word
    '{mcu_read,    24'h00_0104, 8'h5A},
    '{mcu_read,    24'h00_0105, 8'hC3},
    '{snes_read,   24'h00_0104, 8'h00},
    '{snes_read,   24'h00_0105, 8'h00},
    '{snes_read,   24'h00_00A2, 8'h00},  // untouched fill word
    '{blocked_rom, 24'h00_0105, 8'h00}
  };

  logic           CLK2 = 1'b0;
  logic           reset;
  cart_addr_t     snes_addr_in;
  logic           snes_read_in;
  logic           snes_write_in;
  logic           snes_cpu_clk_in;
  byte_t          snes_data_out;
  logic           snes_data_oe;
  cart_addr_t     mcu_addr;
  logic           mcu_rrq;
  logic           mcu_wrq;
  byte_t          mcu_dout;
  byte_t          mcu_din;
  logic           mcu_rdy;
  rom_word_t      rom_data_in;
  rom_word_addr_t rom_addr;
  rom_word_t      rom_data_out;
  logic           rom_we;
  logic           rom_bhe;
  logic           rom_ble;
  byte_t          ram_data_in;
  ram_addr_t      ram_addr;
  byte_t          ram_data_out;
  logic           ram_we;

  rom_word_t rom_mem [256];
  byte_t     ram_mem [256];
  int        cycles = 0;

  always #2 CLK2 = ~CLK2;

  cart_mem_ctrl #(
    .dead_timeout(dead_cycles)
  ) UUT (
    .CLK2            (CLK2),
    .reset           (reset),
    .snes_addr_in    (snes_addr_in),
    .snes_read_in    (snes_read_in),
    .snes_write_in   (snes_write_in),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .snes_data_out   (snes_data_out),
    .snes_data_oe    (snes_data_oe),
    .mcu_addr        (mcu_addr),
    .mcu_rrq         (mcu_rrq),
    .mcu_wrq         (mcu_wrq),
    .mcu_dout        (mcu_dout),
    .mcu_din         (mcu_din),
    .mcu_rdy         (mcu_rdy),
    .rom_data_in     (rom_data_in),
    .rom_addr        (rom_addr),
    .rom_data_out    (rom_data_out),
    .rom_we          (rom_we),
    .rom_bhe         (rom_bhe),
    .rom_ble         (rom_ble),
    .ram_data_in     (ram_data_in),
    .ram_addr        (ram_addr),
    .ram_data_out    (ram_data_out),
    .ram_we          (ram_we)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // even byte lives in the high lane
  function automatic byte_t pick_lane(input rom_word_t w, input logic a0);
    return a0 ? w[7:0] : w[15:8];
  endfunction

  // ----------------------------------------
  // memory models
  // ----------------------------------------
  assign rom_data_in = rom_mem[rom_addr[7:0]];
  assign ram_data_in = ram_mem[ram_addr[7:0]];

  always @(posedge CLK2) begin : mem_models
    logic [31:0] st;
    if (reset) begin
      st = 32'd90;  // seed
      for (int i = 0; i < 256; i++) begin
        st = xorshift(st);
        rom_mem[i] <= st[15:0];
        ram_mem[i] <= st[31:24];
      end
    end else begin
      if (!rom_we && !rom_bhe) rom_mem[rom_addr[7:0]][15:8] <= rom_data_out[15:8];
      if (!rom_we && !rom_ble) rom_mem[rom_addr[7:0]][7:0] <= rom_data_out[7:0];
      if (!ram_we) ram_mem[ram_addr[7:0]] <= ram_data_out;
    end
  end

  always @(posedge CLK2) begin
    cycles <= cycles + 1;
    if (cycles > timeout_cycles) begin
      $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
      stop_with_failure();
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------
  task automatic stop_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s got %02h expected %02h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic issue_request(input logic wr, input cart_addr_t addr, input byte_t data);
    @(posedge CLK2);
    mcu_addr <= addr;
    mcu_dout <= data;  // held until mcu_rdy
    mcu_rrq  <= ~wr;
    mcu_wrq  <= wr;
    @(posedge CLK2);   // strobe sampled here
    mcu_rrq <= 1'b0;
    mcu_wrq <= 1'b0;
  endtask

  // exact = 0 when the latency is not fixed
  task automatic wait_ready(input int exact, input int max_wait);
    int n;
    n = 0;
    do begin
      @(posedge CLK2);
      n++;
      @(negedge CLK2);
      if (n == 1)
        check_bit("mcu_rdy", mcu_rdy, 1'b0);
      else if (exact > 0)
        check_bit("mcu_rdy", mcu_rdy, n == exact);
      if (!mcu_rdy && n >= max_wait) begin
        $display("mcu_rdy stayed low for %0d cycles after the request at %0t", n, $time);
        stop_with_failure();
      end
    end while (!mcu_rdy);
  endtask

  task automatic write_mcu_byte(input cart_addr_t addr, input byte_t data);
    logic      is_ram;
    rom_word_t old;
    rom_word_t exp;
    is_ram = addr[23:19] == RAM_REGION;
    old    = rom_mem[addr[8:1]];
    issue_request(1'b1, addr, data);
    wait_ready(is_ram ? 9 : 0, rom_wait_max);
    if (!is_ram) begin
      exp = addr[0] ? {old[15:8], data} : {data, old[7:0]};
      check_byte("rom high lane", rom_mem[addr[8:1]][15:8], exp[15:8]);
      check_byte("rom low lane", rom_mem[addr[8:1]][7:0], exp[7:0]);
    end
  endtask

  task automatic read_mcu_byte(input cart_addr_t addr, input byte_t exp);
    logic is_ram;
    is_ram = addr[23:19] == RAM_REGION;
    issue_request(1'b0, addr, 8'h00);
    wait_ready(is_ram ? 9 : 0, rom_wait_max);
    check_byte("mcu_din", mcu_din, exp);
  endtask

  task automatic read_console(input cart_addr_t addr);
    @(posedge CLK2);
    snes_addr_in    <= addr;
    snes_read_in    <= 1'b0;
    snes_cpu_clk_in <= 1'b1;
    repeat (4) begin
      @(posedge CLK2);
      snes_cpu_clk_in <= ~snes_cpu_clk_in;
    end
    @(negedge CLK2);
    check_byte("snes_data_out", snes_data_out, pick_lane(rom_mem[addr[8:1]], addr[0]));
    check_bit("snes_data_oe", snes_data_oe, 1'b1);
    @(posedge CLK2);
    snes_read_in    <= 1'b1;
    snes_cpu_clk_in <= 1'b0;  // idle pulse after the access
    repeat (8) @(posedge CLK2);
  endtask

  // console alive with its clock high, so no free rom slot
  task automatic read_rom_blocked(input cart_addr_t addr);
    @(posedge CLK2);
    snes_cpu_clk_in <= 1'b1;
    repeat (8) @(posedge CLK2);
    issue_request(1'b0, addr, 8'h00);
    repeat (40) begin
      @(posedge CLK2);
      @(negedge CLK2);
      check_bit("mcu_rdy", mcu_rdy, 1'b0);
    end
    @(posedge CLK2);
    snes_cpu_clk_in <= 1'b0;
    wait_ready(0, rom_wait_max);
    check_byte("mcu_din", mcu_din, pick_lane(rom_mem[addr[8:1]], addr[0]));
  endtask

  initial begin
    reset           <= 1'b1;
    snes_addr_in    <= '0;
    snes_read_in    <= 1'b1;
    snes_write_in   <= 1'b1;
    snes_cpu_clk_in <= 1'b0;  // console dead from the start
    mcu_addr        <= '0;
    mcu_rrq         <= 1'b0;
    mcu_wrq         <= 1'b0;
    mcu_dout        <= '0;
    repeat (10) @(posedge CLK2);
    reset <= 1'b0;
    @(negedge CLK2);
    check_bit("mcu_rdy", mcu_rdy, 1'b1);
    check_bit("rom_we", rom_we, 1'b1);
    check_bit("ram_we", ram_we, 1'b1);
    check_bit("snes_data_oe", snes_data_oe, 1'b0);

    for (int i = 0; i < n_rows; i++) begin
      case (stim[i].kind)
        mcu_write:   write_mcu_byte(stim[i].addr, stim[i].data);
        mcu_read:    read_mcu_byte(stim[i].addr, stim[i].data);
        snes_read:   read_console(stim[i].addr);
        blocked_rom: read_rom_blocked(stim[i].addr);
      endcase
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* tb.f */
cart_pkg.sv
snes_bus_if.sv
mem_req_if.sv
snes_bus_sampler.sv
mcu_request_port.sv
rom_access_fsm.sv
ram_access_fsm.sv
mem_bus_driver.sv
cart_mem_ctrl.sv
tb_cart_mem_ctrl.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary -j 0
TOP       := tb_cart_mem_ctrl
FILELIST  := tb.f
OBJDIR    := obj_dir
SRCS      := $(shell cat $(FILELIST))
BIN       := $(OBJDIR)/V$(TOP)
PASS_MSG  := *** TEST PASSED ***

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)
